/* uart_cfg_pkg.sv */
/* UART core configuration package
   Bit period encoding, receive credit width and default FIFO depth */

`default_nettype none

package uart_cfg_pkg;

  // Clocks per serial bit as a 12.4 fixed-point value
  // [15:4] integer clocks per sixteenth-bit tick
  // [3:0]  fractional sixteenths, spread over the 16 ticks of a bit
  typedef logic [15:0] bitperiod_t;

  // Receive FIFO depth used unless the top level overrides it
  localparam int RX_DEPTH_DEF = 4;

  // Receive credit counter width, so up to 15 outstanding credits
  localparam int CREDIT_W = 4;

  // Ticks per serial bit, fixed by the 4-bit subtick counters
  localparam int TICKS_PER_BIT = 16;

endpackage : uart_cfg_pkg

`default_nettype wire

/* uart_frame_pkg.sv */
/* UART serial frame package
   Transmitter and receiver state encodings, received word format */

`default_nettype none

package uart_frame_pkg;

  // Transmit shifter states, one per frame section
  typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,  // Line marking, waiting for holding register
    TX_START = 2'd1,  // Start bit (low)
    TX_DATA  = 2'd2,  // 8 data bits, LSB first
    TX_STOP  = 2'd3   // Stop bit (high)
  } tx_state_e;

  // Receiver states
  typedef enum logic [2:0] {
    RX_IDLE  = 3'd0,  // Waiting for falling edge
    RX_START = 3'd1,  // Half-bit wait to confirm start
    RX_DATA  = 3'd2,  // Sampling data bits mid-bit
    RX_STOP  = 3'd3,  // Sampling stop bit
    RX_BREAK = 3'd4   // Line held low, wait for mark
  } rx_state_e;

  // Received word, from receiver to FIFO and from FIFO to host
  typedef struct packed {
    logic [7:0] data;       // Received byte
    logic       frame_err;  // Stop bit read as 0
    logic       overrun;    // Words were dropped before this one
  } rx_word_t;

endpackage : uart_frame_pkg

`default_nettype wire

/* uart_baud_gen.sv */
/* Fractional baud generator
   One tick per sixteenth of a bit, fraction spread over each 16 ticks */

`default_nettype none

module uart_baud_gen import uart_cfg_pkg::*; (
  input  logic       clk,
  input  logic       arstn,
  input  bitperiod_t bitperiod,  // 12.4 clocks per tick
  output logic       tick
);

  logic [11:0] baud_int;   // Down counter for current tick
  logic [3:0]  baud_frac;  // Tick index within the bit
  logic [11:0] per_int;
  logic [3:0]  per_frac;

  assign per_int  = bitperiod[15:4];
  assign per_frac = bitperiod[3:0];

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      baud_int  <= '0;
      baud_frac <= '0;
      tick      <= 1'b0;
    end else begin
      tick <= 1'b0;
      if (baud_int != '0) begin
        baud_int <= baud_int - 12'd1;
      end else begin
        tick <= 1'b1;
        // First per_frac ticks of each bit last one clock longer
        if (per_frac > baud_frac)
          baud_int <= per_int;  // int + 1 clocks
        else
          baud_int <= per_int - 12'd1;  // int clocks
        baud_frac <= baud_frac + 4'd1;  // Wraps every 16 ticks
      end
    end
  end

endmodule : uart_baud_gen

`default_nettype wire

/* uart_tx.sv */
/* 8N1 UART transmitter with one-byte holding register
   Returns a host credit each time the holding register moves to the shifter */

`default_nettype none

module uart_tx import uart_frame_pkg::*; (
  input  logic       clk,
  input  logic       arstn,
  input  logic       tick,
  input  logic       tx_valid,
  input  logic [7:0] tx_data,
  output logic       tx_credit,
  output logic       txd
);

  tx_state_e  state;
  logic [3:0] subtick;    // Tick within current bit
  logic [2:0] bit_cnt;    // Data bit index
  logic [7:0] shifter;    // Bits still to send
  logic [7:0] hold_data;  // Byte waiting for shifter
  logic       hold_full;
  logic       bit_last;   // Last tick of current bit
  logic       load;       // Holding register to shifter
  logic       shift_en;   // Next data bit onto the line

  assign bit_last = tick && (subtick == 4'd15);

  // Idle shifter loads on any tick, busy one only at end of stop bit
  assign load = tick && hold_full &&
                (state == TX_IDLE || (state == TX_STOP && subtick == 4'd15));

  assign shift_en = bit_last &&
                    (state == TX_START || (state == TX_DATA && bit_cnt != 3'd7));

  assign tx_credit = load;  // Credit back as the holding register frees

  // Holding register flag
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn)
      hold_full <= 1'b0;
    else if (tx_valid)
      hold_full <= 1'b1;  // Host only writes while holding a credit
    else if (load)
      hold_full <= 1'b0;
  end

  // Frame sequencer
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state   <= TX_IDLE;
      subtick <= '0;
      bit_cnt <= '0;
      txd     <= 1'b1;  // Line marks after reset
    end else if (load) begin
      state   <= TX_START;
      subtick <= '0;
      txd     <= 1'b0;  // Start bit
    end else if (tick) begin
      subtick <= subtick + 4'd1;
      if (subtick == 4'd15) begin
        case (state)
          TX_START: begin
            state   <= TX_DATA;
            bit_cnt <= '0;
            txd     <= shifter[0];  // Bit 0
          end
          TX_DATA: begin
            if (bit_cnt == 3'd7) begin
              state <= TX_STOP;
              txd   <= 1'b1;  // Stop bit
            end else begin
              bit_cnt <= bit_cnt + 3'd1;
              txd     <= shifter[0];
            end
          end
          TX_STOP: state <= TX_IDLE;  // Nothing held, line stays high
          default: state <= TX_IDLE;
        endcase
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (tx_valid)
      hold_data <= tx_data;
    if (load)
      shifter <= hold_data;
    else if (shift_en)
      shifter <= {1'b0, shifter[7:1]};  // LSB first
  end

endmodule : uart_tx

`default_nettype wire

/* uart_rx.sv */
/* 8N1 UART receiver with two-flop input synchronizer
   Rejects false starts, flags framing errors and holds off during break */

`default_nettype none

module uart_rx import uart_frame_pkg::*; (
  input  logic     clk,
  input  logic     arstn,
  input  logic     tick,
  input  logic     rxd,         // Asynchronous serial input
  output logic     word_valid,  // One cycle, mid stop bit
  output rx_word_t word
);

  logic       rxd_meta;   // First synchronizer stage
  logic       rxd_sync;   // Second stage, safe to use
  rx_state_e  state;
  logic [3:0] subtick;    // Tick count within current bit
  logic [2:0] bit_cnt;    // Data bit index
  logic [7:0] shifter;    // Data collected so far
  logic       sample;     // Mid data bit
  logic       emit;       // Mid stop bit

  assign sample = tick && state == RX_DATA && subtick == 4'd15;
  assign emit   = tick && state == RX_STOP && subtick == 4'd15;

  // Input synchronizer, resets to mark
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  // Receive FSM
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state      <= RX_IDLE;
      subtick    <= '0;
      bit_cnt    <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= emit;
      if (tick) begin
        subtick <= subtick + 4'd1;
        case (state)
          RX_IDLE: begin
            if (!rxd_sync) begin
              state   <= RX_START;  // Falling edge seen
              subtick <= '0;
            end
          end
          RX_START: begin
            if (subtick == 4'd7) begin  // Mid start bit
              if (rxd_sync) begin
                state <= RX_IDLE;  // Glitch, not a start bit
              end else begin
                state   <= RX_DATA;
                subtick <= '0;  // Later samples every 16 ticks
                bit_cnt <= '0;
              end
            end
          end
          RX_DATA: begin
            if (subtick == 4'd15) begin
              bit_cnt <= bit_cnt + 3'd1;
              if (bit_cnt == 3'd7)
                state <= RX_STOP;
            end
          end
          RX_STOP: begin
            if (subtick == 4'd15)
              state <= rxd_sync ? RX_IDLE : RX_BREAK;  // Low stop bit may be break
          end
          RX_BREAK: begin
            if (rxd_sync)
              state <= RX_IDLE;  // Mark ends hold-off
          end
          default: state <= RX_IDLE;
        endcase
      end
    end
  end

  // Data path
  always_ff @(posedge clk) begin
    if (sample)
      shifter <= {rxd_sync, shifter[7:1]};  // LSB arrives first
    if (emit) begin
      word.data      <= shifter;
      word.frame_err <= ~rxd_sync;
      word.overrun   <= 1'b0;  // Set downstream in the FIFO
    end
  end

endmodule : uart_rx

`default_nettype wire

/* uart_rx_fifo.sv */
/* Receive FIFO with overrun marking and credit-gated delivery
   Words that find the FIFO full are dropped and flagged on the next word kept */

`default_nettype none

module uart_rx_fifo import uart_cfg_pkg::*, uart_frame_pkg::*; #(
  parameter int RX_DEPTH = 4
) (
  input  logic     clk,
  input  logic     arstn,
  input  logic     word_valid,
  input  rx_word_t word,
  input  logic     rx_credit,  // One pulse per word the host can take
  output logic     rx_valid,
  output rx_word_t rx_word
);

  localparam int PTR_W = $clog2(RX_DEPTH);
  localparam int CNT_W = $clog2(RX_DEPTH + 1);

  rx_word_t            mem [RX_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;    // Words stored
  logic [CREDIT_W-1:0] credits;  // Host credits not yet used
  logic                drop;     // Word lost since last store
  logic                deliver;
  logic                wr_en;

  // Pulse arriving this cycle already counts
  assign deliver = (credits != '0 || rx_credit) && count != '0;
  assign wr_en   = word_valid && (count != CNT_W'(RX_DEPTH) || deliver);

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credits  <= '0;  // Host starts with nothing granted
      drop     <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= deliver;
      count    <= count + CNT_W'(wr_en) - CNT_W'(deliver);
      credits  <= credits + CREDIT_W'(rx_credit) - CREDIT_W'(deliver);
      if (wr_en)
        wr_ptr <= (wr_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (deliver)
        rd_ptr <= (rd_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (wr_en)
        drop <= 1'b0;  // Reported in the stored word
      else if (word_valid)
        drop <= 1'b1;  // Full, word lost
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr]         <= word;
      mem[wr_ptr].overrun <= drop;
    end
    if (deliver)
      rx_word <= mem[rd_ptr];
  end

endmodule : uart_rx_fifo

`default_nettype wire

/* uart_core.sv */
/* UART core top level
   Baud generator, buffered transmitter, receiver and credit-gated receive FIFO */

`default_nettype none

module uart_core import uart_cfg_pkg::*, uart_frame_pkg::*; #(
  parameter int RX_DEPTH = RX_DEPTH_DEF
) (
  input  logic       clk,
  input  logic       arstn,
  input  logic       tx_valid,   // Spends the host's single tx credit
  input  logic       rxd,
  input  logic [7:0] tx_data,
  input  bitperiod_t bitperiod,  // Clocks per bit, 12.4
  input  logic       rx_credit,
  output logic       tx_credit,
  output logic       txd,
  output logic       rx_valid,
  output rx_word_t   rx_word
);

  logic     tick;        // Sixteenth-bit strobe
  logic     word_valid;  // Receiver to FIFO
  rx_word_t word;

  uart_baud_gen baud_i (
    .clk       (clk),
    .arstn     (arstn),
    .bitperiod (bitperiod),
    .tick      (tick)
  );

  uart_tx tx_i (
    .clk       (clk),
    .arstn     (arstn),
    .tick      (tick),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .tx_credit (tx_credit),
    .txd       (txd)
  );

  uart_rx rx_i (
    .clk        (clk),
    .arstn      (arstn),
    .tick       (tick),
    .rxd        (rxd),
    .word_valid (word_valid),
    .word       (word)
  );

  uart_rx_fifo #(.RX_DEPTH(RX_DEPTH)) fifo_i (
    .clk        (clk),
    .arstn      (arstn),
    .word_valid (word_valid),
    .word       (word),
    .rx_credit  (rx_credit),
    .rx_valid   (rx_valid),
    .rx_word    (rx_word)
  );

endmodule : uart_core

`default_nettype wire

/* tb_clk_gen.sv */
/* Testbench clock and reset generator
   Free-running clock, active-low reset released after a few cycles */

`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic arstn
);

  timeunit 1ns;
  timeprecision 100ps;

  initial clk = 1'b0;
  always #(PERIOD_NS / 2) clk = ~clk;

  initial begin
    arstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arstn = 1'b1;  // Released off the edge, like the other inputs
  end

endmodule : tb_clk_gen

`default_nettype wire

/* tb_uart_core.sv */
/* Testbench for the UART core
   Loopback and direct-line tests checked against a FIFO and credit model */

`default_nettype none

module tb_uart_core import uart_cfg_pkg::*, uart_frame_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int         DEPTH      = 4;
  localparam bitperiod_t BITPERIOD  = 16'h00A3;  // 10 3/16 clocks per tick
  localparam int         BIT_CLKS   = TICKS_PER_BIT * int'(BITPERIOD[15:4])
                                      + int'(BITPERIOD[3:0]);  // Whole ticks plus fraction
  localparam int         FRAME_CLKS = 10 * BIT_CLKS;
  localparam int         MAX_CYCLES = (26 * FRAME_CLKS * 3) / 2;  // 26 frames plus slack

  logic       clk;
  logic       arstn;
  logic       tx_valid;
  logic [7:0] tx_data;
  logic       rx_credit;
  logic       tx_credit;
  logic       txd;
  logic       rxd;
  logic       rx_valid;
  rx_word_t   rx_word;
  logic       loopback;  // 1: rxd from txd, 0: rxd from line
  logic       line;      // Directly driven serial line

  rx_word_t exp_q[$];       // Words the host should see, in order
  int       fill;           // Model FIFO occupancy
  bit       drop_pend;      // Model drop flag
  int       tx_credits;     // Host tx credits held
  int       rx_credits;     // rx credits granted, not yet used
  int       credit_pulses;  // tx_credit pulses in current test
  int       errors;
  int       err_at_start;
  int       tests_run;
  int       tests_failed;
  int       cycles;

  tb_clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(3)) clk_gen_i (.clk(clk), .arstn(arstn));

  assign rxd = loopback ? txd : line;

  uart_core #(.RX_DEPTH(DEPTH)) dut_i (
    .clk       (clk),
    .arstn     (arstn),
    .tx_valid  (tx_valid),
    .rxd       (rxd),
    .tx_data   (tx_data),
    .bitperiod (BITPERIOD),
    .rx_credit (rx_credit),
    .tx_credit (tx_credit),
    .txd       (txd),
    .rx_valid  (rx_valid),
    .rx_word   (rx_word)
  );

  // Expected word for a byte, framing result and pending drop
  function automatic rx_word_t ref_word(input logic [7:0] data, input logic ferr,
                                        input logic ovr);
    rx_word_t w;
    w.data      = data;
    w.frame_err = ferr;
    w.overrun   = ovr;
    return w;
  endfunction

  // Model of the receive FIFO store decision
  task automatic expect_word(input logic [7:0] data, input logic ferr);
    if (fill == DEPTH) begin
      drop_pend = 1'b1;  // Full, word lost
    end else begin
      exp_q.push_back(ref_word(data, ferr, drop_pend));
      drop_pend = 1'b0;
      fill++;
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) step();
  endtask

  // Waits for a credit, then writes one byte
  task automatic send_byte(input logic [7:0] b);
    while (tx_credits == 0)
      step();
    tx_valid = 1'b1;
    tx_data  = b;
    tx_credits--;  // Spent by the write
    if (loopback)
      expect_word(b, 1'b0);
    step();
    tx_valid = 1'b0;
  endtask

  task automatic grant_rx(input int n);
    rx_credit = 1'b1;
    rx_credits += n;
    wait_cycles(n);  // One pulse per cycle
    rx_credit = 1'b0;
  endtask

  task automatic wait_pending(input int n);
    while (exp_q.size() > n)
      step();
  endtask

  // Last byte in the shifter, then its frame reaches the FIFO
  task automatic wait_tx_idle();
    while (tx_credits == 0)
      step();
    wait_cycles(FRAME_CLKS + 20);
  endtask

  // Drives one frame on the line with the given stop bit
  task automatic drive_frame(input logic [7:0] b, input logic stop);
    line = 1'b0;
    wait_cycles(BIT_CLKS);
    for (int i = 0; i < 8; i++) begin
      line = b[i];
      wait_cycles(BIT_CLKS);
    end
    line = stop;
    wait_cycles(BIT_CLKS);
  endtask

  task automatic compare_field(input string name, input logic [7:0] want,
                               input logic [7:0] got);
    assert (got == want) else begin
      $display("Fail at %0d ns: %s expected 0x%02h got 0x%02h", $time, name, want, got);
      errors++;
    end
  endtask

  task automatic start_test();
    err_at_start  = errors;
    credit_pulses = 0;
  endtask

  task automatic end_test(input string name);
    assert (exp_q.size() == 0) else begin
      $display("%0d expected words never arrived", exp_q.size());
      errors++;
    end
    tests_run++;
    if (errors != err_at_start) begin
      tests_failed++;
      $display("test %s: FAIL, %0d errors", name, errors - err_at_start);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // Outputs settle by the falling edge
  always @(negedge clk) begin
    rx_word_t want;
    if (arstn && tx_credit) begin
      tx_credits++;
      credit_pulses++;
      assert (tx_credits <= 1) else begin
        $display("Host holds %0d tx credits at %0d ns, more than one", tx_credits, $time);
        errors++;
      end
    end
    if (arstn && rx_valid) begin
      assert (rx_credits > 0) else begin
        $display("rx_valid at %0d ns without a granted credit", $time);
        errors++;
      end
      if (rx_credits > 0)
        rx_credits--;
      assert (exp_q.size() != 0) else begin
        $display("Unexpected word 0x%02h at %0d ns", rx_word.data, $time);
        errors++;
      end
      if (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        fill--;
        compare_field("rx_word.data", want.data, rx_word.data);
        compare_field("rx_word.frame_err", {7'd0, want.frame_err}, {7'd0, rx_word.frame_err});
        compare_field("rx_word.overrun", {7'd0, want.overrun}, {7'd0, rx_word.overrun});
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run still going after %0d clock cycles", cycles);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    logic [7:0] b;
    void'($urandom(32'h8017));
    tx_valid     = 1'b0;
    tx_data      = 8'h00;
    rx_credit    = 1'b0;
    line         = 1'b1;  // Mark
    loopback     = 1'b1;
    fill         = 0;
    drop_pend    = 1'b0;
    tx_credits   = 1;
    rx_credits   = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycles       = 0;
    @(posedge arstn);
    step();

    start_test();  // Reset state
    assert (txd === 1'b1) else begin
      $display("Fail at %0d ns: txd expected 1 got %b", $time, txd);
      errors++;
    end
    repeat (100) begin
      @(negedge clk);
      assert (rx_valid === 1'b0 && tx_credit === 1'b0) else begin
        $display("Output active after reset with no input at %0d ns", $time);
        errors++;
      end
    end
    step();
    end_test("reset_state");

    start_test();
    grant_rx(1);
    send_byte(8'hA5);
    wait_pending(0);
    assert (credit_pulses == 1) else begin
      $display("Fail at %0d ns: tx_credit pulses expected 1 got %0d", $time, credit_pulses);
      errors++;
    end
    end_test("single_loopback");

    start_test();
    grant_rx(12);  // Granted ahead
    for (int i = 0; i < 12; i++) begin
      b = 8'($urandom());
      send_byte(b);
    end
    wait_pending(0);
    end_test("back_to_back");

    start_test();
    for (int i = 0; i < 4; i++)
      send_byte(8'h30 + 8'(i));
    wait_tx_idle();  // Any rx_valid here has no credit
    for (int i = 0; i < 4; i++) begin
      grant_rx(1);
      wait_pending(3 - i);
    end
    end_test("rx_backpressure");

    start_test();
    for (int i = 0; i < 6; i++)
      send_byte(8'h50 + 8'(i));
    wait_tx_idle();
    grant_rx(4);
    wait_pending(0);
    grant_rx(1);
    send_byte(8'h5A);  // Carries overrun
    wait_pending(0);
    end_test("overrun");

    start_test();
    loopback = 1'b0;
    grant_rx(2);  // Spare credit exposes a spurious word
    expect_word(8'hC3, 1'b1);
    drive_frame(8'hC3, 1'b0);
    wait_cycles(3 * BIT_CLKS);  // Break
    line = 1'b1;
    wait_pending(0);
    wait_cycles(2 * BIT_CLKS);
    loopback = 1'b1;
    send_byte(8'h3C);  // Uses the spare credit
    wait_pending(0);
    end_test("framing_break");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule : tb_uart_core

`default_nettype wire

/* tb.f */
uart_cfg_pkg.sv
uart_frame_pkg.sv
uart_baud_gen.sv
uart_tx.sv
uart_rx.sv
uart_rx_fifo.sv
uart_core.sv
tb_clk_gen.sv
tb_uart_core.sv

/* run.sh */
#!/bin/sh
# Build and run the UART core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_core -f tb.f -o sim_uart
./obj_dir/sim_uart > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
  exit 1
fi
exit 0
